// File: hdl/axi_proto_pkg.sv
// AXI4 protocol field types shared by the subordinate engines
// EXOKAY and DECERR are listed for completeness, the design never returns them

package axi_proto_pkg;

    // AxBURST encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,  // Same address every beat
        INCR  = 2'b01,  // Address steps by the beat size
        WRAP  = 2'b10   // Answered with SLVERR here
    } axi_burst_t;

    // xRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01, // Exclusive access only
        SLVERR = 2'b10,
        DECERR = 2'b11  // No decoder behind this port
    } axi_resp_t;

    // AxLEN, beats minus one, 1 to 256 beats
    typedef logic [7:0] axi_len_t;

    // AxSIZE, log2 of bytes per beat
    typedef logic [2:0] axi_size_t;

endpackage

// File: hdl/sram_cfg_pkg.sv
// Default geometry of the SRAM subsystem
// The top level takes these as parameter defaults, data width must be 32 or 64

package sram_cfg_pkg;

    localparam int ADDR_WIDTH_DEF = 12; // Byte address, 4 KiB
    localparam int DATA_WIDTH_DEF = 32;
    localparam int ID_WIDTH_DEF   = 4;

    // Derived from the defaults above
    localparam int BYTES_DEF   = DATA_WIDTH_DEF / 8;       // Strobe bits per word
    localparam int WORD_AW_DEF = ADDR_WIDTH_DEF - $clog2(BYTES_DEF);
    localparam int DEPTH_DEF   = 1 << WORD_AW_DEF;         // Words in the array

endpackage

// File: hdl/axi_sub_wr.sv
// AXI4 write engine, one burst at a time, one component write per W beat
// WRAP bursts drain all W beats and answer SLVERR without touching memory
// AWSIZE wider than the data bus is not checked
`timescale 1ns/100ps

module axi_sub_wr #(
    parameter int AW = 12,
    parameter int DW = 32,
    parameter int IW = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    // AW channel
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AW-1:0]             awaddr,
    input  logic [IW-1:0]             awid,
    input  axi_proto_pkg::axi_len_t   awlen,
    input  axi_proto_pkg::axi_size_t  awsize,
    input  axi_proto_pkg::axi_burst_t awburst,
    // W channel
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [DW-1:0]             wdata,
    input  logic [DW/8-1:0]           wstrb,
    input  logic                      wlast,
    // B channel
    output logic                      bvalid,
    input  logic                      bready,
    output logic [IW-1:0]             bid,
    output axi_proto_pkg::axi_resp_t  bresp,
    // Component write request
    output logic                      wr_req,
    input  logic                      wr_gnt,
    output logic [AW-1:0]             wr_addr,
    output logic [DW-1:0]             wr_data,
    output logic [DW/8-1:0]           wr_strb
);
    import axi_proto_pkg::*;

    typedef enum logic [1:0] {st_idle, st_data, st_resp} wr_state_t;

    wr_state_t  state;
    logic [AW-1:0] addr_q;      // Burst address, low bits dropped once stepped
    axi_size_t  size_q;
    axi_burst_t burst_q;
    axi_len_t   beats_q;        // Beats left after the next W transfer
    logic       beat_pend;      // Beat held until granted
    logic       last_q;         // Held beat closes the burst
    logic [AW-1:0] size_mask;
    logic [AW-1:0] addr_aln;
    logic       beat_done;
    logic       w_xfer;

    assign size_mask = {AW{1'b1}} << size_q;
    assign addr_aln  = addr_q & size_mask;   // Aligned down to the beat size
    assign wr_addr   = addr_aln;
    assign wr_req    = beat_pend && (burst_q != WRAP);
    // WRAP beats retire on their own
    assign beat_done = beat_pend && (wr_gnt || (burst_q == WRAP));
    assign wready    = (state == st_data) && !beat_pend;
    assign w_xfer    = wvalid && wready;
    assign bvalid    = (state == st_resp);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            awready   <= 1'b0;
            beat_pend <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    awready <= 1'b1;              // Rises the cycle after reset
                    if (awvalid && awready) begin
                        awready <= 1'b0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (w_xfer)
                        beat_pend <= 1'b1;
                    if (beat_done) begin
                        beat_pend <= 1'b0;
                        if (last_q)
                            state <= st_resp;
                    end
                end
                st_resp: begin
                    if (bready) begin             // B transfer
                        state   <= st_idle;
                        awready <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Burst context and beat payload
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q  <= awaddr;
            size_q  <= awsize;
            burst_q <= awburst;
            beats_q <= awlen;
            bid     <= awid;                                 // ID echo
            bresp   <= (awburst == WRAP) ? SLVERR : OKAY;    // Sticky for the burst
        end
        if (w_xfer) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
            last_q  <= wlast || (beats_q == '0);  // Either ends the burst
            beats_q <= beats_q - 1'b1;
        end
        if (beat_done && (burst_q == INCR))
            addr_q <= addr_aln + (AW'(1) << size_q);  // Wraps at top of memory
    end

endmodule

// File: hdl/axi_sub_rd.sv
// AXI4 read engine, one burst at a time, returned words go through a 2-entry skid buffer
// At most two reads are outstanding, so rready low never loses data
// WRAP bursts return zero data with SLVERR and issue no reads
`timescale 1ns/100ps

module axi_sub_rd #(
    parameter int AW = 12,
    parameter int DW = 32,
    parameter int IW = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    // AR channel
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [AW-1:0]             araddr,
    input  logic [IW-1:0]             arid,
    input  axi_proto_pkg::axi_len_t   arlen,
    input  axi_proto_pkg::axi_size_t  arsize,
    input  axi_proto_pkg::axi_burst_t arburst,
    // R channel
    output logic                      rvalid,
    input  logic                      rready,
    output logic [IW-1:0]             rid,
    output logic [DW-1:0]             rdata,
    output axi_proto_pkg::axi_resp_t  rresp,
    output logic                      rlast,
    // Component read request and return
    output logic                      rd_req,
    input  logic                      rd_gnt,
    output logic [AW-1:0]             rd_addr,
    input  logic                      rd_data_valid,  // Cycle after a read grant
    input  logic [DW-1:0]             sram_rdata
);
    import axi_proto_pkg::*;

    logic          busy;
    logic [AW-1:0] addr_q;
    axi_size_t     size_q;
    axi_burst_t    burst_q;
    logic [8:0]    issue_cnt;     // Beats left to issue, up to 256
    axi_len_t      ret_cnt;       // Beats left to return after the next one
    logic [AW-1:0] size_mask;
    logic [AW-1:0] addr_aln;
    logic          is_wrap;
    logic          issue_left;
    logic          fake_push;     // WRAP beat, no memory read
    logic          push;
    logic          pop;
    logic [1:0]    fill;          // Buffer use plus read in flight
    logic [DW-1:0] buf_data [2];
    logic          buf_last [2];
    axi_resp_t     buf_resp [2];
    logic          wr_ptr;
    logic          rd_ptr;
    logic [1:0]    buf_cnt;

    assign size_mask  = {AW{1'b1}} << size_q;
    assign addr_aln   = addr_q & size_mask;
    assign rd_addr    = addr_aln;
    assign is_wrap    = (burst_q == WRAP);
    assign issue_left = busy && (issue_cnt != '0);
    assign pop        = rvalid && rready;
    assign fill       = buf_cnt + {1'b0, rd_data_valid} - {1'b0, pop};
    assign rd_req     = issue_left && !is_wrap && (fill < 2'd2);  // Keep a slot free
    assign fake_push  = issue_left && is_wrap && (fill < 2'd2);
    assign push       = rd_data_valid || fake_push;

    assign rvalid = (buf_cnt != 2'd0);
    assign rdata  = buf_data[rd_ptr];
    assign rresp  = buf_resp[rd_ptr];
    assign rlast  = buf_last[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            arready <= 1'b0;
            buf_cnt <= 2'd0;
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
        end else begin
            if (!busy) begin
                arready <= !(arvalid && arready);  // High from the cycle after reset
                if (arvalid && arready)
                    busy <= 1'b1;
            end else if (pop && rlast) begin       // Burst fully returned
                busy    <= 1'b0;
                arready <= 1'b1;
            end
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    // Burst context, counters and buffer entries
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q    <= araddr;
            size_q    <= arsize;
            burst_q   <= arburst;
            rid       <= arid;
            issue_cnt <= {1'b0, arlen} + 9'd1;
            ret_cnt   <= arlen;
        end else begin
            if (rd_gnt || fake_push) begin
                issue_cnt <= issue_cnt - 9'd1;
                if (burst_q == INCR)
                    addr_q <= addr_aln + (AW'(1) << size_q);
            end
            if (push)
                ret_cnt <= ret_cnt - 1'b1;
        end
        if (push) begin
            buf_data[wr_ptr] <= rd_data_valid ? sram_rdata : '0;
            buf_last[wr_ptr] <= (ret_cnt == '0);     // Returns stay in order
            buf_resp[wr_ptr] <= is_wrap ? SLVERR : OKAY;
        end
    end

endmodule

// File: hdl/axi_sub.sv
// AXI4 subordinate, write and read engines sharing one component port
// Ties alternate starting with write, SRAM read latency is fixed at one cycle
`timescale 1ns/100ps

module axi_sub #(
    parameter int AW = 12,
    parameter int DW = 32,
    parameter int IW = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [AW-1:0]                   awaddr,
    input  logic [IW-1:0]                   awid,
    input  axi_proto_pkg::axi_len_t         awlen,
    input  axi_proto_pkg::axi_size_t        awsize,
    input  axi_proto_pkg::axi_burst_t       awburst,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [DW-1:0]                   wdata,
    input  logic [DW/8-1:0]                 wstrb,
    input  logic                            wlast,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [IW-1:0]                   bid,
    output axi_proto_pkg::axi_resp_t        bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [AW-1:0]                   araddr,
    input  logic [IW-1:0]                   arid,
    input  axi_proto_pkg::axi_len_t         arlen,
    input  axi_proto_pkg::axi_size_t        arsize,
    input  axi_proto_pkg::axi_burst_t       arburst,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [IW-1:0]                   rid,
    output logic [DW-1:0]                   rdata,
    output axi_proto_pkg::axi_resp_t        rresp,
    output logic                            rlast,
    // SRAM side, word addressed
    output logic                            sram_cs,
    output logic                            sram_we,
    output logic [AW-$clog2(DW/8)-1:0]      sram_addr,
    output logic [DW-1:0]                   sram_wdata,
    output logic [DW/8-1:0]                 sram_strb,
    input  logic [DW-1:0]                   sram_rdata
);
    localparam int BW = $clog2(DW / 8);  // Byte offset bits

    logic          wr_req;
    logic          wr_gnt;
    logic [AW-1:0] wr_addr;
    logic [DW-1:0] wr_data;
    logic [DW/8-1:0] wr_strb;
    logic          rd_req;
    logic          rd_gnt;
    logic [AW-1:0] rd_addr;
    logic          rd_data_valid;
    logic          prio_wr;          // Write wins the next tie

    axi_sub_wr #(.AW(AW), .DW(DW), .IW(IW)) i_wr (.*);
    axi_sub_rd #(.AW(AW), .DW(DW), .IW(IW)) i_rd (.*);

    assign wr_gnt = wr_req && (!rd_req || prio_wr);
    assign rd_gnt = rd_req && !wr_gnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_wr       <= 1'b1;
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_gnt;     // SRAM data valid one cycle later
            if (wr_gnt)
                prio_wr <= 1'b0;
            else if (rd_gnt)
                prio_wr <= 1'b1;
        end
    end

    assign sram_cs    = wr_gnt || rd_gnt;
    assign sram_we    = wr_gnt;
    assign sram_addr  = wr_gnt ? wr_addr[AW-1:BW] : rd_addr[AW-1:BW];  // Byte to word
    assign sram_wdata = wr_data;
    assign sram_strb  = wr_strb;

endmodule

// File: hdl/axi_sram.sv
// Single-port synchronous SRAM, byte write enables, one-cycle read latency
// Contents are undefined until written, rdata holds between reads
`timescale 1ns/100ps

module axi_sram #(
    parameter int DEPTH = 1024,   // Words
    parameter int DW    = 32
) (
    input  logic                     clk,
    input  logic                     cs,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,    // Word address
    input  logic [DW-1:0]            wdata,
    input  logic [DW/8-1:0]          strb,
    output logic [DW-1:0]            rdata
);
    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cs && we) begin
            // Only strobed bytes change
            for (int b = 0; b < DW / 8; b++) begin
                if (strb[b])
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        if (cs && !we)
            rdata <= mem[addr];  // Registered read port
    end

endmodule

// File: hdl/axi_sram_top.sv
// On-chip SRAM behind an AXI4 subordinate port
// One write and one read burst in flight, no exclusive access, no user or QoS bits
`timescale 1ns/100ps

module axi_sram_top #(
    parameter int AW = sram_cfg_pkg::ADDR_WIDTH_DEF,
    parameter int DW = sram_cfg_pkg::DATA_WIDTH_DEF,
    parameter int IW = sram_cfg_pkg::ID_WIDTH_DEF
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AW-1:0]             awaddr,
    input  logic [IW-1:0]             awid,
    input  axi_proto_pkg::axi_len_t   awlen,
    input  axi_proto_pkg::axi_size_t  awsize,
    input  axi_proto_pkg::axi_burst_t awburst,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [DW-1:0]             wdata,
    input  logic [DW/8-1:0]           wstrb,
    input  logic                      wlast,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [IW-1:0]             bid,
    output axi_proto_pkg::axi_resp_t  bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [AW-1:0]             araddr,
    input  logic [IW-1:0]             arid,
    input  axi_proto_pkg::axi_len_t   arlen,
    input  axi_proto_pkg::axi_size_t  arsize,
    input  axi_proto_pkg::axi_burst_t arburst,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [IW-1:0]             rid,
    output logic [DW-1:0]             rdata,
    output axi_proto_pkg::axi_resp_t  rresp,
    output logic                      rlast
);
    localparam int BW    = $clog2(DW / 8);
    localparam int DEPTH = 1 << (AW - BW);   // Words behind the byte address range

    logic              sram_cs;
    logic              sram_we;
    logic [AW-BW-1:0]  sram_addr;
    logic [DW-1:0]     sram_wdata;
    logic [DW/8-1:0]   sram_strb;
    logic [DW-1:0]     sram_rdata;

    axi_sub #(.AW(AW), .DW(DW), .IW(IW)) i_axi_sub (.*);

    axi_sram #(
        .DEPTH(DEPTH),
        .DW   (DW)
    ) i_sram (
        .clk  (clk),
        .cs   (sram_cs),
        .we   (sram_we),
        .addr (sram_addr),
        .wdata(sram_wdata),
        .strb (sram_strb),
        .rdata(sram_rdata)
    );

endmodule

// File: verification/axi_sram_tb_tasks.svh
// LFSR, AXI burst drivers, memory model and typed compare tasks
// Included inside axi_sram_tb, uses its signals, counters and model array
`ifndef AXI_SRAM_TB_TASKS_SVH
`define AXI_SRAM_TB_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[62:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // x^16+x^14+x^13+x^11+1
    end
    return v;
endfunction

// Next beat address per burst kind
function automatic logic [AW-1:0] next_addr(input logic [AW-1:0] a, input axi_burst_t burst);
    logic [AW-1:0] aln;
    aln = a & ~AW'(NB - 1);                       // Aligned down to the beat size
    return (burst == INCR) ? aln + AW'(NB) : a;   // Wraps at top of memory
endfunction

function automatic logic [DW-1:0] model_word(input logic [AW-1:0] a);
    logic [DW-1:0] w;
    for (int b = 0; b < NB; b++)
        w[b*8 +: 8] = mem_model[(a & ~AW'(NB - 1)) + AW'(b)];
    return w;
endfunction

function automatic void model_write(input logic [AW-1:0] a, input logic [DW-1:0] d,
                                    input logic [NB-1:0] s);
    for (int b = 0; b < NB; b++)
        if (s[b])
            mem_model[(a & ~AW'(NB - 1)) + AW'(b)] = d[b*8 +: 8];   // Strobed bytes only
endfunction

// Fill byte from every bit of its byte address
function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
    logic [AW-1:0] x;
    logic [DW-1:0] w;
    for (int b = 0; b < NB; b++) begin
        x = (a & ~AW'(NB - 1)) + AW'(b);
        w[b*8 +: 8] = 8'(x ^ (x >> 5)) ^ 8'hA5;
    end
    return w;
endfunction

task automatic check_data(input string name, input logic [DW-1:0] got, input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_id(input string name, input logic [IW-1:0] got, input logic [IW-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_last(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic report_case(input int n, input string what);
    $display("case %0d %s: %0d checks, %0d errors", n, what,
             checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
endtask

// AW, then W beats, then B, model updated per accepted beat
task automatic write_burst(input logic [AW-1:0] addr, input logic [IW-1:0] id,
                           input axi_len_t len, input axi_burst_t burst,
                           input logic fill, input logic bp);
    logic [AW-1:0] a;
    logic [DW-1:0] d;
    logic [NB-1:0] s;
    logic hs;
    logic [IW-1:0] got_id;
    axi_resp_t got_resp;
    a = addr;
    awaddr = addr;
    awid = id;
    awlen = len;
    awsize = axi_size_t'($clog2(NB));
    awburst = burst;
    awvalid = 1'b1;
    do begin
        @(negedge clk);          // Ready sampled mid-cycle
        hs = awready;
        @(posedge clk);
        #1;
    end while (!hs);
    awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
        d = fill ? fill_word(a) : DW'(rand_bits(DW));
        s = fill ? '1 : NB'(rand_bits(NB));
        wdata = d;
        wstrb = s;
        wlast = (i == int'(len));
        wvalid = 1'b1;
        do begin
            @(negedge clk);
            hs = wready;
            @(posedge clk);
            #1;
        end while (!hs);
        if (burst != WRAP)
            model_write(a, d, s);
        a = next_addr(a, burst);
    end
    wvalid = 1'b0;
    wlast = 1'b0;
    do begin
        bready = bp ? 1'(rand_bits(1)) : 1'b1;   // Random stall under back-pressure
        @(negedge clk);
        hs = bvalid && bready;
        got_id = bid;
        got_resp = bresp;
        @(posedge clk);
        #1;
    end while (!hs);
    bready = 1'b0;
    check_id("bid", got_id, id);
    check_resp("bresp", got_resp, (burst == WRAP) ? SLVERR : OKAY);
endtask

// AR, then every R beat checked against the model
task automatic read_burst(input logic [AW-1:0] addr, input logic [IW-1:0] id,
                          input axi_len_t len, input axi_burst_t burst, input logic bp);
    logic [AW-1:0] a;
    logic hs;
    logic [DW-1:0] got_data;
    logic [IW-1:0] got_id;
    axi_resp_t got_resp;
    logic got_last;
    a = addr;
    araddr = addr;
    arid = id;
    arlen = len;
    arsize = axi_size_t'($clog2(NB));
    arburst = burst;
    arvalid = 1'b1;
    do begin
        @(negedge clk);
        hs = arready;
        @(posedge clk);
        #1;
    end while (!hs);
    arvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
        do begin
            rready = bp ? 1'(rand_bits(1)) : 1'b1;
            @(negedge clk);
            hs = rvalid && rready;
            got_data = rdata;
            got_id = rid;
            got_resp = rresp;
            got_last = rlast;
            @(posedge clk);
            #1;
        end while (!hs);
        check_data("rdata", got_data, (burst == WRAP) ? '0 : model_word(a));  // WRAP reads zero
        check_resp("rresp", got_resp, (burst == WRAP) ? SLVERR : OKAY);
        check_id("rid", got_id, id);
        check_last("rlast", got_last, i == int'(len));
        a = next_addr(a, burst);
    end
    rready = 1'b0;
endtask

`endif

// File: verification/axi_sram_tb.sv
// Testbench for axi_sram_top, random AXI bursts checked against a byte-array model
// Beat size always equals the data width, the whole memory is filled before any read
`timescale 1ns/100ps

module axi_sram_tb;
    import axi_proto_pkg::*;
    import sram_cfg_pkg::*;

    localparam int AW       = ADDR_WIDTH_DEF;
    localparam int DW       = DATA_WIDTH_DEF;
    localparam int IW       = ID_WIDTH_DEF;
    localparam int NB       = DW / 8;            // Bytes per beat
    localparam int DEPTH    = (1 << AW) / NB;
    localparam int N_SINGLE = 24;
    localparam int N_INCR   = 16;
    localparam int N_BP     = 12;
    // Worst case beats of fill, singles, INCR, FIXED, WRAP and back-pressure rounds
    localparam int TOTAL_BEATS = DEPTH + 2 * N_SINGLE + 32 * N_INCR + 32 + 12 + 48 * N_BP;
    localparam int MAX_CYCLES  = TOTAL_BEATS * 40 + 1000;

    logic clk;
    logic reset = 1'b1;
    // Driven by the testbench
    logic awvalid = 1'b0, wvalid = 1'b0, wlast = 1'b0, bready = 1'b0;
    logic arvalid = 1'b0, rready = 1'b0;
    logic [AW-1:0] awaddr = '0, araddr = '0;
    logic [IW-1:0] awid = '0, arid = '0;
    axi_len_t awlen = '0, arlen = '0;
    axi_size_t awsize = '0, arsize = '0;
    axi_burst_t awburst = INCR, arburst = INCR;
    logic [DW-1:0] wdata = '0;
    logic [NB-1:0] wstrb = '0;
    // Driven by the DUT
    logic awready, wready, bvalid, arready, rvalid, rlast;
    logic [IW-1:0] bid, rid;
    logic [DW-1:0] rdata;
    axi_resp_t bresp, rresp;

    logic [7:0] mem_model [1 << AW];   // Byte-addressed reference memory
    logic [15:0] lfsr = 16'd28853;
    int checks = 0;
    int errors = 0;
    int mark_checks = 0;
    int mark_errors = 0;

    axi_sram_top #(.AW(AW), .DW(DW), .IW(IW)) u_dut (.*);

    `include "axi_sram_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // Watchdog sized from the beat budget
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [AW-1:0] addr;
        logic [AW-1:0] raddr;
        logic [IW-1:0] id;
        axi_len_t len;
        axi_len_t rlen;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);                  // Ready flags rise here
        #1;
        check_flag("awready", awready, 1'b1);
        check_flag("arready", arready, 1'b1);
        check_flag("wready", wready, 1'b0);
        check_flag("bvalid", bvalid, 1'b0);
        check_flag("rvalid", rvalid, 1'b0);
        report_case(1, "reset state");
        for (int k = 0; k < DEPTH / 256; k++)   // 256-beat bursts over the whole array
            write_burst(AW'(k * 256 * NB), '0, 8'd255, INCR, 1'b1, 1'b0);
        report_case(0, "memory fill");
        for (int n = 0; n < N_SINGLE; n++) begin
            addr = AW'(rand_bits(AW));
            id = IW'(rand_bits(IW));
            write_burst(addr, id, '0, INCR, 1'b0, 1'b0);
            read_burst(addr, id, '0, INCR, 1'b0);
        end
        report_case(2, "single beats with strobes");
        for (int n = 0; n < N_INCR; n++) begin
            addr = AW'(rand_bits(AW));   // May cross the top of memory
            id = IW'(rand_bits(IW));
            len = axi_len_t'(rand_bits(4));
            write_burst(addr, id, len, INCR, 1'b0, 1'b0);
            read_burst(addr, id, len, INCR, 1'b0);
        end
        report_case(3, "INCR bursts");
        for (int n = 0; n < 2; n++) begin
            addr = AW'(rand_bits(AW));
            id = IW'(rand_bits(IW));
            write_burst(addr, id, 8'd7, FIXED, 1'b0, 1'b0);
            read_burst(addr, id, 8'd7, FIXED, 1'b0);
        end
        report_case(4, "FIXED bursts");
        addr = AW'(rand_bits(AW));
        id = IW'(rand_bits(IW));
        write_burst(addr, id, 8'd3, WRAP, 1'b0, 1'b0);
        read_burst(addr, id, 8'd3, WRAP, 1'b0);
        read_burst(addr, id, 8'd3, INCR, 1'b0);   // Contents unchanged
        report_case(5, "WRAP bursts");
        for (int n = 0; n < N_BP; n++) begin
            addr = AW'(rand_bits(AW - 2));                      // Lower quarter
            raddr = AW'((1 << (AW - 1)) + rand_bits(AW - 2));  // Upper half, no overlap
            len = axi_len_t'(rand_bits(4));
            rlen = axi_len_t'(rand_bits(4));
            fork
                write_burst(addr, IW'(n), len, INCR, 1'b0, 1'b1);
                read_burst(raddr, IW'(n + 1), rlen, INCR, 1'b1);
            join
            read_burst(addr, IW'(n), len, INCR, 1'b1);
        end
        // No extra beat left behind
        check_flag("rvalid", rvalid, 1'b0);
        check_flag("bvalid", bvalid, 1'b0);
        report_case(6, "concurrent back-pressure");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
hdl/axi_proto_pkg.sv
hdl/sram_cfg_pkg.sv
hdl/axi_sub_wr.sv
hdl/axi_sub_rd.sv
hdl/axi_sub.sv
hdl/axi_sram.sv
hdl/axi_sram_top.sv
verification/axi_sram_tb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = axi_sram_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = test failed
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
